// File: tb.f
src/mem_bus_pkg.sv
src/cache_pkg.sv
src/native_bus_if.sv
src/l1_cache.sv
src/bus_merge.sv
src/l2_cache.sv
src/ext_mem.sv
verification/mem_model.sv
verification/tb_ext_mem.sv

// File: verification/tb_ext_mem.sv
`timescale 1ns/10ps

module tb_ext_mem import mem_bus_pkg::*, cache_pkg::*; ();

   // About 300 accesses of under 40 cycles each plus margin
   localparam int MAX_CYCLES = 20000;
   localparam int RANDOM_OPS = 200;

   logic  clk_i;
   logic  rst_i;
   logic  i_req_i;
   addr_t i_addr_i;
   data_t i_rdata_o;
   logic  i_ack_o;
   logic  d_req_i;
   logic  d_ctrl_i;
   addr_t d_addr_i;
   data_t d_wdata_i;
   strb_t d_wstrb_i;
   data_t d_rdata_o;
   logic  d_ack_o;
   logic  mem_req_o;
   addr_t mem_addr_o;
   data_t mem_wdata_o;
   strb_t mem_wstrb_o;
   data_t mem_rdata_i;
   logic  mem_ack_i;

   data_t  sb [2**ADDR_W]; // Expected memory contents
   integer seed;
   int     cycle_count = 0;

   ext_mem dut_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .i_req_i     (i_req_i),
      .i_addr_i    (i_addr_i),
      .i_rdata_o   (i_rdata_o),
      .i_ack_o     (i_ack_o),
      .d_req_i     (d_req_i),
      .d_ctrl_i    (d_ctrl_i),
      .d_addr_i    (d_addr_i),
      .d_wdata_i   (d_wdata_i),
      .d_wstrb_i   (d_wstrb_i),
      .d_rdata_o   (d_rdata_o),
      .d_ack_o     (d_ack_o),
      .mem_req_o   (mem_req_o),
      .mem_addr_o  (mem_addr_o),
      .mem_wdata_o (mem_wdata_o),
      .mem_wstrb_o (mem_wstrb_o),
      .mem_rdata_i (mem_rdata_i),
      .mem_ack_i   (mem_ack_i)
   );

   mem_model mem_i (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .mem_req_i   (mem_req_o),
      .mem_addr_i  (mem_addr_o),
      .mem_wdata_i (mem_wdata_o),
      .mem_wstrb_i (mem_wstrb_o),
      .mem_rdata_o (mem_rdata_i),
      .mem_ack_o   (mem_ack_i)
   );

   always #50 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES) begin
         $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
         abort_run();
      end
   end

   task automatic abort_run();
      $display("Testbench failed");
      $fatal(1, "Run stopped at first error");
   endtask

   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (act !== exp) begin
         $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Fail at %0t ns: %s expected %b, got %b", $time, name, exp, act);
         abort_run();
      end
   endtask

   function automatic data_t preload_word(input addr_t a);
      return data_t'(a) * 32'h0001_0003 + 32'd7;
   endfunction

   // Expected word after a strobed write
   function automatic data_t apply_strobes(input data_t old_w, input data_t new_w,
                                           input strb_t strb);
      data_t mask;
      mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      return (old_w & ~mask) | (new_w & mask);
   endfunction

   task automatic fetch(input addr_t a, output data_t rd, output int lat);
      @(negedge clk_i);
      i_req_i  = 1'b1;
      i_addr_i = a;
      @(negedge clk_i);
      i_req_i = 1'b0;
      lat     = 1;
      while (!i_ack_o) begin
         @(negedge clk_i);
         lat++;
      end
      rd = i_rdata_o;
   endtask

   task automatic data_access(input logic ctrl, input addr_t a, input data_t wd,
                              input strb_t ws, output data_t rd, output int lat);
      @(negedge clk_i);
      d_req_i   = 1'b1;
      d_ctrl_i  = ctrl;
      d_addr_i  = a;
      d_wdata_i = wd;
      d_wstrb_i = ws;
      @(negedge clk_i);
      d_req_i = 1'b0;
      lat     = 1;
      while (!d_ack_o) begin
         @(negedge clk_i);
         lat++;
      end
      rd = d_rdata_o;
   endtask

   // Both ports start in the same cycle
   task automatic dual_access(input addr_t ia, input addr_t da, input data_t wd,
                              input strb_t ws, output data_t ird, output data_t drd);
      logic i_done;
      logic d_done;
      @(negedge clk_i);
      i_req_i   = 1'b1;
      i_addr_i  = ia;
      d_req_i   = 1'b1;
      d_ctrl_i  = 1'b0;
      d_addr_i  = da;
      d_wdata_i = wd;
      d_wstrb_i = ws;
      i_done    = 1'b0;
      d_done    = 1'b0;
      while (!(i_done && d_done)) begin
         @(negedge clk_i);
         i_req_i = 1'b0;
         d_req_i = 1'b0;
         if (i_ack_o) begin
            i_done = 1'b1;
            ird    = i_rdata_o;
         end
         if (d_ack_o) begin
            d_done = 1'b1;
            drd    = d_rdata_o;
         end
      end
   endtask

   task automatic fetch_check(input addr_t a, output int lat);
      data_t rd;
      fetch(a, rd, lat);
      check_data("i_rdata_o", sb[a], rd);
   endtask

   task automatic data_read_check(input addr_t a);
      data_t rd;
      int    lat;
      data_access(1'b0, a, '0, '0, rd, lat);
      check_data("d_rdata_o", sb[a], rd);
   endtask

   task automatic data_write(input addr_t a, input data_t wd, input strb_t ws);
      data_t rd;
      int    lat;
      data_access(1'b0, a, wd, ws, rd, lat);
      sb[a] = apply_strobes(sb[a], wd, ws);
   endtask

   task automatic repeated_fetches();
      int lat;
      for (int n = 0; n < 8; n++) begin
         fetch_check(addr_t'(12'h100 + n), lat);
      end
      for (int n = 0; n < 8; n++) begin
         fetch_check(addr_t'(12'h100 + n), lat);
         check_bit("i_ack_o", 1'b1, lat == 1); // Hit acks in the next cycle
      end
   endtask

   task automatic merged_writes();
      int lat;
      data_write(12'h200, 32'h1234_5678, 4'hF);
      data_write(12'h201, 32'hAABB_CCDD, 4'h3);
      data_write(12'h202, 32'h5566_7788, 4'h8);
      for (int n = 0; n < 3; n++) begin
         data_read_check(addr_t'(12'h200 + n));
      end
      // Lines now valid in the dcache
      data_write(12'h200, 32'h00EE_0000, 4'h4);
      data_write(12'h201, 32'h9900_0000, 4'h8);
      data_read_check(12'h200);
      data_read_check(12'h201);
      for (int n = 0; n < 3; n++) begin
         fetch_check(addr_t'(12'h200 + n), lat);
      end
   endtask

   task automatic same_cycle_requests();
      data_t ird;
      data_t drd;
      dual_access(12'h110, 12'h300, '0, '0, ird, drd);
      check_data("i_rdata_o", sb[12'h110], ird);
      check_data("d_rdata_o", sb[12'h300], drd);
      dual_access(12'h111, 12'h301, 32'hCAFE_F00D, 4'hF, ird, drd);
      sb[12'h301] = 32'hCAFE_F00D;
      check_data("i_rdata_o", sb[12'h111], ird);
      data_read_check(12'h301);
      dual_access(12'h110, 12'h300, '0, '0, ird, drd); // Both hit now
      check_data("i_rdata_o", sb[12'h110], ird);
      check_data("d_rdata_o", sb[12'h300], drd);
   endtask

   task automatic drain_status();
      data_t rd;
      int    lat;
      int    polls;
      // More writes than the L2 buffer holds
      for (int n = 0; n < WTB_DEPTH + 2; n++) begin
         data_write(addr_t'(12'h400 + n), 32'h0F0F_0000 + n, 4'hF);
      end
      // Last write still sits in the L2 buffer
      data_access(1'b1, '0, '0, '0, rd, lat);
      check_bit("d_ack_o", 1'b1, lat == 1);
      check_bit("d_rdata_o[0]", 1'b0, rd[0]);
      polls = 1;
      while (!rd[0] && polls < 100) begin
         data_access(1'b1, '0, '0, '0, rd, lat);
         check_bit("d_ack_o", 1'b1, lat == 1);
         polls++;
      end
      check_bit("d_rdata_o[0]", 1'b1, rd[0]);
      for (int n = 0; n < WTB_DEPTH + 2; n++) begin
         check_data($sformatf("memory[%h]", 12'h400 + n), sb[12'h400 + n],
                    mem_i.backdoor_read(addr_t'(12'h400 + n)));
      end
   endtask

   task automatic control_invalidate();
      data_t rd;
      data_t new_word;
      int    lat;
      data_read_check(12'h500);
      new_word = ~sb[12'h500];
      mem_i.backdoor_write(12'h500, new_word);
      data_read_check(12'h500); // Stale copy still cached
      data_access(1'b1, '0, '0, 4'hF, rd, lat);
      check_bit("d_ack_o", 1'b1, lat == 1);
      sb[12'h500] = new_word;
      data_read_check(12'h500);
   endtask

   task automatic random_traffic();
      logic [31:0] r;
      addr_t       ia;
      addr_t       da;
      data_t       wd;
      strb_t       ws;
      data_t       ird;
      data_t       drd;
      int          lat;
      for (int n = 0; n < RANDOM_OPS; n++) begin
         r  = $random(seed);
         wd = $random(seed);
         ia = addr_t'(12'h700 + r[5:0]);                      // Never written
         da = addr_t'((r[12] ? 12'hA00 : 12'h600) + r[11:6]); // Aliases in both levels
         ws = (r[16:13] == '0) ? 4'hF : r[16:13];
         case (r[31:30])
            2'd0: fetch_check(ia, lat);
            2'd1: data_read_check(da);
            2'd2: data_write(da, wd, ws);
            default: begin
               if (r[17]) begin
                  dual_access(ia, da, wd, ws, ird, drd);
                  sb[da] = apply_strobes(sb[da], wd, ws);
               end else begin
                  dual_access(ia, da, '0, '0, ird, drd);
                  check_data("d_rdata_o", sb[da], drd);
               end
               check_data("i_rdata_o", sb[ia], ird);
            end
         endcase
      end
   endtask

   initial begin
      seed      = 32'h9a97_05dd;
      clk_i     = 1'b0;
      rst_i     = 1'b1;
      i_req_i   = 1'b0;
      i_addr_i  = '0;
      d_req_i   = 1'b0;
      d_ctrl_i  = 1'b0;
      d_addr_i  = '0;
      d_wdata_i = '0;
      d_wstrb_i = '0;
      for (int a = 0; a < 2**ADDR_W; a++) begin
         sb[a] = preload_word(addr_t'(a));
         mem_i.backdoor_write(addr_t'(a), sb[a]);
      end
      repeat (2) @(negedge clk_i);
      rst_i = 1'b0;
      check_bit("i_ack_o", 1'b0, i_ack_o);
      check_bit("d_ack_o", 1'b0, d_ack_o);
      check_bit("mem_req_o", 1'b0, mem_req_o);

      repeated_fetches();
      merged_writes();
      same_cycle_requests();
      drain_status();
      control_invalidate();
      random_traffic();

      $display("Testbench passed");
      $finish;
   end

endmodule

// File: verification/mem_model.sv
`timescale 1ns/10ps

module mem_model import mem_bus_pkg::*; (
   input  logic  clk_i,
   input  logic  rst_i,
   input  logic  mem_req_i,
   input  addr_t mem_addr_i,
   input  data_t mem_wdata_i,
   input  strb_t mem_wstrb_i,
   output data_t mem_rdata_o,
   output logic  mem_ack_o
);

   localparam int LATENCY = 3; // Cycles from req to ack

   data_t mem [2**ADDR_W];

   logic  busy_q;
   int    wait_q;
   addr_t addr_q;
   data_t wdata_q;
   strb_t wstrb_q;

   always @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         busy_q      <= 1'b0;
         wait_q      <= 0;
         mem_ack_o   <= 1'b0;
         mem_rdata_o <= '0;
      end else begin
         mem_ack_o <= 1'b0;
         if (mem_req_i) begin
            busy_q  <= 1'b1;
            wait_q  <= 0;
            addr_q  <= mem_addr_i;
            wdata_q <= mem_wdata_i;
            wstrb_q <= mem_wstrb_i;
         end else if (busy_q) begin
            if (wait_q == LATENCY - 2) begin
               busy_q      <= 1'b0;
               mem_ack_o   <= 1'b1;
               mem_rdata_o <= mem[addr_q];
               for (int b = 0; b < STRB_W; b++) begin
                  if (wstrb_q[b]) begin
                     mem[addr_q][8*b +: 8] <= wdata_q[8*b +: 8];
                  end
               end
            end
            wait_q <= wait_q + 1;
         end
      end
   end

   // Backdoor access for preload and checks
   task automatic backdoor_write(input addr_t a, input data_t d);
      mem[a] = d;
   endtask

   function automatic data_t backdoor_read(input addr_t a);
      return mem[a];
   endfunction

endmodule

// File: src/ext_mem.sv
`timescale 1ns/10ps

module ext_mem import mem_bus_pkg::*; (
   input  logic  clk_i,
   input  logic  rst_i,

   // Instruction port
   input  logic  i_req_i,
   input  addr_t i_addr_i,
   output data_t i_rdata_o,
   output logic  i_ack_o,

   // Data port
   input  logic  d_req_i,
   input  logic  d_ctrl_i,
   input  addr_t d_addr_i,
   input  data_t d_wdata_i,
   input  strb_t d_wstrb_i,
   output data_t d_rdata_o,
   output logic  d_ack_o,

   // External memory port
   output logic  mem_req_o,
   output addr_t mem_addr_o,
   output data_t mem_wdata_o,
   output strb_t mem_wstrb_o,
   input  data_t mem_rdata_i,
   input  logic  mem_ack_i
);

   native_bus_if icache_be ();
   native_bus_if dcache_be ();
   native_bus_if l2_fe ();

   logic invalidate;
   logic invalidate_pending;
   logic l2_invalidate;
   logic l2_wtb_empty;

   // Read-only, never invalidated
   l1_cache #(.HAS_CTRL(1'b0)) icache (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .fe_req_i     (i_req_i),
      .fe_ctrl_i    (1'b0),
      .fe_addr_i    (i_addr_i),
      .fe_wdata_i   ('0),
      .fe_wstrb_i   ('0),
      .fe_rdata_o   (i_rdata_o),
      .fe_ack_o     (i_ack_o),
      .be           (icache_be),
      .wtb_empty_i  (1'b1),
      .invalidate_o ()
   );

   l1_cache #(.HAS_CTRL(1'b1)) dcache (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .fe_req_i     (d_req_i),
      .fe_ctrl_i    (d_ctrl_i),
      .fe_addr_i    (d_addr_i),
      .fe_wdata_i   (d_wdata_i),
      .fe_wstrb_i   (d_wstrb_i),
      .fe_rdata_o   (d_rdata_o),
      .fe_ack_o     (d_ack_o),
      .be           (dcache_be),
      .wtb_empty_i  (l2_wtb_empty),
      .invalidate_o (invalidate)
   );

   bus_merge merge_i_d (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .m0    (icache_be), // Instruction side wins ties
      .m1    (dcache_be),
      .s     (l2_fe)
   );

   // Hold the L2 invalidate until no request is on its front end
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         invalidate_pending <= 1'b0;
      end else if (invalidate) begin
         invalidate_pending <= 1'b1;
      end else if (!l2_fe.req) begin
         invalidate_pending <= 1'b0;
      end
   end

   assign l2_invalidate = invalidate_pending && !l2_fe.req;

   l2_cache l2cache (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .fe           (l2_fe),
      .invalidate_i (l2_invalidate),
      .wtb_empty_o  (l2_wtb_empty),
      .mem_req_o    (mem_req_o),
      .mem_addr_o   (mem_addr_o),
      .mem_wdata_o  (mem_wdata_o),
      .mem_wstrb_o  (mem_wstrb_o),
      .mem_rdata_i  (mem_rdata_i),
      .mem_ack_i    (mem_ack_i)
   );

endmodule

// File: src/l2_cache.sv
`timescale 1ns/10ps

module l2_cache import mem_bus_pkg::*, cache_pkg::*; (
   input  logic        clk_i,
   input  logic        rst_i,
   native_bus_if.slave fe,
   input  logic        invalidate_i,
   output logic        wtb_empty_o,
   output logic        mem_req_o,
   output addr_t       mem_addr_o,
   output data_t       mem_wdata_o,
   output strb_t       mem_wstrb_o,
   input  data_t       mem_rdata_i,
   input  logic        mem_ack_i
);

   l2_state_e state_q;

   addr_t addr_q;
   data_t wdata_q;
   strb_t wstrb_q;
   logic  wr_pend_q; // Write waiting for buffer room
   logic  ack_q;
   data_t rdata_q;   // Also the fill word on a miss

   logic [L2_LINES-1:0]        valid_q;
   logic [ADDR_W-1:L2_INDEX_W] tag_mem  [L2_LINES];
   data_t                      data_mem [L2_LINES];

   // Write buffer FIFO
   addr_t            wtb_addr [WTB_DEPTH];
   data_t            wtb_data [WTB_DEPTH];
   strb_t            wtb_strb [WTB_DEPTH];
   wtb_ptr_t         wr_ptr_q;
   wtb_ptr_t         rd_ptr_q;
   logic [WTB_PTR_W:0] count_q;

   // Memory port, one transaction at a time
   logic  mem_req_q;
   logic  mem_busy_q;
   logic  mem_rd_q;
   addr_t mem_addr_q;
   data_t mem_wdata_q;
   strb_t mem_wstrb_q;

   l2_index_t fe_idx;
   l2_index_t q_idx;
   logic      fe_hit;
   logic      q_hit;
   logic      wtb_full;
   logic      push;
   logic      pop;
   logic      start_wr;
   logic      start_rd;

   assign fe_idx = fe.addr[L2_INDEX_W-1:0];
   assign q_idx  = addr_q[L2_INDEX_W-1:0];
   assign fe_hit = valid_q[fe_idx] && (tag_mem[fe_idx] == fe.addr[ADDR_W-1:L2_INDEX_W]);
   assign q_hit  = valid_q[q_idx] && (tag_mem[q_idx] == addr_q[ADDR_W-1:L2_INDEX_W]);

   assign wtb_empty_o = (count_q == '0);
   assign wtb_full    = (count_q == WTB_DEPTH);
   assign push        = wr_pend_q && !wtb_full;
   assign pop         = mem_ack_i && mem_busy_q && !mem_rd_q;
   assign start_wr    = !mem_busy_q && !wtb_empty_o;
   assign start_rd    = !mem_busy_q && wtb_empty_o && (state_q == L2_DRAIN);

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q   <= L2_IDLE;
         wr_pend_q <= 1'b0;
         ack_q     <= 1'b0;
      end else begin
         ack_q <= 1'b0;
         unique case (state_q)
            L2_IDLE: begin
               if (push) begin
                  wr_pend_q <= 1'b0;
                  ack_q     <= 1'b1;
               end else if (fe.req && |fe.wstrb) begin
                  wr_pend_q <= 1'b1;
               end else if (fe.req && fe_hit) begin
                  ack_q <= 1'b1;
               end else if (fe.req) begin
                  state_q <= L2_DRAIN;
               end
            end
            L2_DRAIN: begin
               if (start_rd) begin
                  state_q <= L2_MEM_READ;
               end
            end
            L2_MEM_READ: begin
               if (mem_ack_i) begin
                  state_q <= L2_FILL;
               end
            end
            L2_FILL: begin
               ack_q   <= 1'b1;
               state_q <= L2_IDLE;
            end
            default: state_q <= L2_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == L2_IDLE && fe.req) begin
         addr_q  <= fe.addr;
         wdata_q <= fe.wdata;
         wstrb_q <= fe.wstrb;
      end
      if (state_q == L2_IDLE && fe.req && ~|fe.wstrb) begin
         rdata_q <= data_mem[fe_idx]; // Overwritten later on a miss
      end else if (state_q == L2_MEM_READ && mem_ack_i) begin
         rdata_q <= mem_rdata_i;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         valid_q <= '0;
      end else if (invalidate_i) begin
         valid_q <= '0;
      end else if (state_q == L2_FILL) begin
         valid_q[q_idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (push && q_hit) begin
         data_mem[q_idx] <= merge_bytes(data_mem[q_idx], wdata_q, wstrb_q);
      end
      if (state_q == L2_FILL) begin
         tag_mem[q_idx]  <= addr_q[ADDR_W-1:L2_INDEX_W];
         data_mem[q_idx] <= rdata_q;
      end
      if (push) begin
         wtb_addr[wr_ptr_q] <= addr_q;
         wtb_data[wr_ptr_q] <= wdata_q;
         wtb_strb[wr_ptr_q] <= wstrb_q;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         mem_req_q  <= 1'b0;
         mem_busy_q <= 1'b0;
         mem_rd_q   <= 1'b0;
      end else begin
         mem_req_q <= start_wr || start_rd;
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         if (push && !pop) begin
            count_q <= count_q + 1'b1;
         end else if (pop && !push) begin
            count_q <= count_q - 1'b1;
         end
         if (start_wr || start_rd) begin
            mem_busy_q <= 1'b1;
            mem_rd_q   <= start_rd;
         end else if (mem_ack_i) begin
            mem_busy_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (start_rd) begin
         mem_addr_q  <= addr_q;
         mem_wdata_q <= '0;
         mem_wstrb_q <= '0;
      end else if (start_wr) begin
         mem_addr_q  <= wtb_addr[rd_ptr_q]; // Oldest entry first
         mem_wdata_q <= wtb_data[rd_ptr_q];
         mem_wstrb_q <= wtb_strb[rd_ptr_q];
      end
   end

   assign mem_req_o   = mem_req_q;
   assign mem_addr_o  = mem_addr_q;
   assign mem_wdata_o = mem_wdata_q;
   assign mem_wstrb_o = mem_wstrb_q;

   assign fe.ack   = ack_q;
   assign fe.rdata = rdata_q;

endmodule

// File: src/bus_merge.sv
`timescale 1ns/10ps

module bus_merge import mem_bus_pkg::*; (
   input  logic         clk_i,
   input  logic         rst_i,
   native_bus_if.slave  m0,
   native_bus_if.slave  m1,
   native_bus_if.master s
);

   // Requests waiting for a grant
   logic  pend0_q;
   logic  pend1_q;
   addr_t addr0_q;
   addr_t addr1_q;
   data_t wdata0_q;
   data_t wdata1_q;
   strb_t wstrb0_q;
   strb_t wstrb1_q;

   logic  busy_q; // Grant locked until slave ack
   logic  gnt_q;  // 0 selects m0
   logic  s_req_q;
   addr_t s_addr_q;
   data_t s_wdata_q;
   strb_t s_wstrb_q;

   logic want0;
   logic want1;
   logic grant0;
   logic grant1;

   assign want0  = m0.req || pend0_q;
   assign want1  = m1.req || pend1_q;
   assign grant0 = !busy_q && want0;
   assign grant1 = !busy_q && !want0 && want1; // m0 has priority

   always_ff @(posedge clk_i) begin
      if (m0.req) begin
         addr0_q  <= m0.addr;
         wdata0_q <= m0.wdata;
         wstrb0_q <= m0.wstrb;
      end
      if (m1.req) begin
         addr1_q  <= m1.addr;
         wdata1_q <= m1.wdata;
         wstrb1_q <= m1.wstrb;
      end
      if (grant0) begin
         s_addr_q  <= m0.req ? m0.addr : addr0_q;
         s_wdata_q <= m0.req ? m0.wdata : wdata0_q;
         s_wstrb_q <= m0.req ? m0.wstrb : wstrb0_q;
      end else if (grant1) begin
         s_addr_q  <= m1.req ? m1.addr : addr1_q;
         s_wdata_q <= m1.req ? m1.wdata : wdata1_q;
         s_wstrb_q <= m1.req ? m1.wstrb : wstrb1_q;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         pend0_q <= 1'b0;
         pend1_q <= 1'b0;
         busy_q  <= 1'b0;
         gnt_q   <= 1'b0;
         s_req_q <= 1'b0;
      end else begin
         s_req_q <= grant0 || grant1;
         pend0_q <= want0 && !grant0;
         pend1_q <= want1 && !grant1;
         if (grant0 || grant1) begin
            busy_q <= 1'b1;
            gnt_q  <= grant1;
         end else if (s.ack) begin
            busy_q <= 1'b0;
         end
      end
   end

   assign s.req   = s_req_q;
   assign s.addr  = s_addr_q;
   assign s.wdata = s_wdata_q;
   assign s.wstrb = s_wstrb_q;

   assign m0.ack   = busy_q && !gnt_q && s.ack;
   assign m1.ack   = busy_q && gnt_q && s.ack;
   assign m0.rdata = gnt_q ? '0 : s.rdata;
   assign m1.rdata = gnt_q ? s.rdata : '0;

endmodule

// File: src/l1_cache.sv
`timescale 1ns/10ps

module l1_cache import mem_bus_pkg::*, cache_pkg::*; #(
   parameter bit HAS_CTRL = 1'b0
) (
   input  logic         clk_i,
   input  logic         rst_i,
   input  logic         fe_req_i,
   input  logic         fe_ctrl_i,
   input  addr_t        fe_addr_i,
   input  data_t        fe_wdata_i,
   input  strb_t        fe_wstrb_i,
   output data_t        fe_rdata_o,
   output logic         fe_ack_o,
   native_bus_if.master be,
   input  logic         wtb_empty_i,
   output logic         invalidate_o
);

   l1_state_e state_q;

   // Request held from capture until ack
   addr_t addr_q;
   data_t wdata_q;
   strb_t wstrb_q;
   logic  ctrl_q;

   logic [L1_LINES-1:0]         valid_q;
   logic [ADDR_W-1:L1_INDEX_W]  tag_mem  [L1_LINES];
   data_t                       data_mem [L1_LINES];

   l1_index_t idx;
   logic      is_write;
   logic      hit;
   logic      local_ack; // Answered without the back end
   logic      be_done;

   assign idx      = addr_q[L1_INDEX_W-1:0];
   assign is_write = |wstrb_q;
   assign hit      = valid_q[idx] && (tag_mem[idx] == addr_q[ADDR_W-1:L1_INDEX_W]);

   // Control accesses and read hits finish in the lookup cycle
   assign local_ack = (state_q == L1_LOOKUP) && (ctrl_q || (hit && !is_write));
   assign be_done   = (state_q == L1_BE_WAIT) && be.ack;

   assign fe_ack_o = local_ack || be_done;

   always_comb begin
      if (ctrl_q) begin
         fe_rdata_o = {{(DATA_W-1){1'b0}}, wtb_empty_i}; // Status in bit 0
      end else if (state_q == L1_BE_WAIT) begin
         fe_rdata_o = be.rdata;
      end else begin
         fe_rdata_o = data_mem[idx];
      end
   end

   assign invalidate_o = (state_q == L1_LOOKUP) && ctrl_q && is_write;

   // Misses and all writes go to the back end
   assign be.req   = (state_q == L1_LOOKUP) && !local_ack;
   assign be.addr  = addr_q;
   assign be.wdata = wdata_q;
   assign be.wstrb = wstrb_q;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state_q <= L1_IDLE;
         ctrl_q  <= 1'b0;
      end else begin
         unique case (state_q)
            L1_IDLE: begin
               if (fe_req_i) begin
                  state_q <= L1_LOOKUP;
                  ctrl_q  <= HAS_CTRL && fe_ctrl_i;
               end
            end
            L1_LOOKUP: begin
               state_q <= local_ack ? L1_IDLE : L1_BE_WAIT;
            end
            L1_BE_WAIT: begin
               if (be.ack) begin
                  state_q <= L1_IDLE;
               end
            end
            default: state_q <= L1_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (state_q == L1_IDLE && fe_req_i) begin
         addr_q  <= fe_addr_i;
         wdata_q <= fe_wdata_i;
         wstrb_q <= fe_wstrb_i;
      end
   end

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         valid_q <= '0;
      end else if (invalidate_o) begin
         valid_q <= '0;
      end else if (be_done && !is_write) begin
         valid_q[idx] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      // Write hit keeps the line current, no allocate on write miss
      if (state_q == L1_LOOKUP && !ctrl_q && is_write && hit) begin
         data_mem[idx] <= merge_bytes(data_mem[idx], wdata_q, wstrb_q);
      end
      if (be_done && !is_write) begin
         tag_mem[idx]  <= addr_q[ADDR_W-1:L1_INDEX_W];
         data_mem[idx] <= be.rdata;
      end
   end

endmodule

// File: src/native_bus_if.sv
`timescale 1ns/10ps

interface native_bus_if import mem_bus_pkg::*; ();

   logic  req;   // One-cycle pulse
   addr_t addr;
   data_t wdata;
   strb_t wstrb; // Zero for reads
   data_t rdata; // Valid with ack
   logic  ack;   // One-cycle pulse

   modport master (
      output req, addr, wdata, wstrb,
      input  rdata, ack
   );

   modport slave (
      input  req, addr, wdata, wstrb,
      output rdata, ack
   );

endinterface

// File: src/cache_pkg.sv
package cache_pkg;

   // L1 geometry, one word per line
   localparam int L1_INDEX_W = 4;
   localparam int L1_LINES   = 2 ** L1_INDEX_W;

   // L2 geometry
   localparam int L2_INDEX_W = 6;
   localparam int L2_LINES   = 2 ** L2_INDEX_W;

   // L2 write buffer
   localparam int WTB_DEPTH = 4;
   localparam int WTB_PTR_W = $clog2(WTB_DEPTH);

   typedef logic [L1_INDEX_W-1:0] l1_index_t;
   typedef logic [L2_INDEX_W-1:0] l2_index_t;
   typedef logic [WTB_PTR_W-1:0]  wtb_ptr_t;

   typedef enum logic [1:0] {
      L1_IDLE,
      L1_LOOKUP,
      L1_BE_WAIT  // Waiting on back-end ack
   } l1_state_e;

   typedef enum logic [1:0] {
      L2_IDLE,
      L2_DRAIN,     // Read miss waits for empty write buffer
      L2_MEM_READ,
      L2_FILL
   } l2_state_e;

endpackage

// File: src/mem_bus_pkg.sv
package mem_bus_pkg;

   // Word-addressed buses throughout
   localparam int ADDR_W = 12;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [STRB_W-1:0] strb_t; // All zeros on a read

   // Byte lanes of new_w replace those of old_w where strb is set
   function automatic data_t merge_bytes(
      input data_t old_w,
      input data_t new_w,
      input strb_t strb
   );
      data_t res;
      res = old_w;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

endpackage
